/* project.f */
hdl/cpuPkg.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/hazardUnit.sv
hdl/myCpuTop.sv
tb/cpuTrace_checker.sv
tb/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator and run; the exit status is the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuTb -f project.f -o cpuSim \
	&& ./obj_dir/cpuSim +verilator+error+limit+100 \
	|| exit 1

/* tb/cpuTb.sv */
`default_nettype none

module cpuClockGen #(
	parameter int HALF_PERIOD = 50
) (
	output logic clk_o
);
	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end
endmodule

module cpuTb;
	import cpuPkg::*;

	localparam word_t RESET_PC = 32'h00400000;
	// The self-loop sits at word 25 of the program.
	localparam word_t LOOP_PC = RESET_PC + 32'd100;
	localparam int TIMEOUT_CYCLES = 500;

	logic clk;
	logic rst_i;
	logic instSramEn;
	word_t instSramAddr;
	word_t instSramRdata;
	logic dataSramEn;
	logic [3:0] dataSramWen;
	word_t dataSramAddr;
	word_t dataSramWdata;
	word_t dataSramRdata = '0;
	word_t debugWbPc;
	logic [3:0] debugWbRfWen;
	regAddr_t debugWbRfWnum;
	word_t debugWbRfWdata;
	word_t rom [0:63];
	word_t ram [0:63];

	cpuClockGen clockGen_inst (.clk_o(clk));

	myCpuTop #(.RESET_PC(RESET_PC)) myCpuTop_inst (
		.clk              (clk),
		.rst_i            (rst_i),
		.instSramEn_o     (instSramEn),
		.instSramAddr_o   (instSramAddr),
		.instSramRdata_i  (instSramRdata),
		.dataSramEn_o     (dataSramEn),
		.dataSramWen_o    (dataSramWen),
		.dataSramAddr_o   (dataSramAddr),
		.dataSramWdata_o  (dataSramWdata),
		.dataSramRdata_i  (dataSramRdata),
		.debugWbPc_o      (debugWbPc),
		.debugWbRfWen_o   (debugWbRfWen),
		.debugWbRfWnum_o  (debugWbRfWnum),
		.debugWbRfWdata_o (debugWbRfWdata)
	);

	bind myCpuTop cpuTrace_checker #(.RESET_PC(RESET_PC)) traceCheck_inst (
		.clk              (clk),
		.rst_i            (rst_i),
		.instSramEn_i     (instSramEn_o),
		.instSramAddr_i   (instSramAddr_o),
		.instSramRdata_i  (instSramRdata_i),
		.dataSramEn_i     (dataSramEn_o),
		.dataSramWen_i    (dataSramWen_o),
		.dataSramAddr_i   (dataSramAddr_o),
		.dataSramWdata_i  (dataSramWdata_o),
		.debugWbPc_i      (debugWbPc_o),
		.debugWbRfWen_i   (debugWbRfWen_o),
		.debugWbRfWnum_i  (debugWbRfWnum_o),
		.debugWbRfWdata_i (debugWbRfWdata_o)
	);

	function automatic word_t rInstr(int rs, int rt, int rd, logic [5:0] fn);
		return {OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic word_t iInstr(logic [5:0] op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [5:0] romIndex(word_t addr);
		word_t off;
		off = addr - RESET_PC;
		return off[7:2];
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test program.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic loadProgram();
		for (int i = 0; i < 64; i++) begin
			rom[i] = '0;
		end
		// Dependent ALU chain.
		rom[0] = iInstr(OPC_ADDIU, 0, 1, 5);
		rom[1] = iInstr(OPC_ADDIU, 1, 2, 7);
		rom[2] = rInstr(1, 2, 3, FN_ADDU);
		rom[3] = rInstr(3, 1, 4, FN_SUBU);
		rom[4] = rInstr(4, 3, 5, FN_AND);
		rom[5] = rInstr(4, 3, 6, FN_OR);
		rom[6] = iInstr(OPC_ADDIU, 0, 7, -3);
		rom[7] = rInstr(7, 1, 8, FN_SLT);
		rom[8] = rInstr(1, 7, 9, FN_SLT);
		// Stores, then load-use.
		rom[9] = iInstr(OPC_SW, 0, 6, 8);
		rom[10] = iInstr(OPC_SW, 0, 7, 12);
		rom[11] = iInstr(OPC_LW, 0, 10, 8);
		rom[12] = rInstr(10, 1, 11, FN_ADDU);
		rom[13] = iInstr(OPC_LW, 0, 12, 12);
		// Taken on a load result; word 16 is skipped.
		rom[14] = iInstr(OPC_BEQ, 12, 7, 2);
		rom[15] = iInstr(OPC_ADDIU, 0, 13, 1);
		rom[16] = iInstr(OPC_ADDIU, 0, 13, 99);
		rom[17] = iInstr(OPC_ADDIU, 1, 14, -5);
		rom[18] = iInstr(OPC_BEQ, 14, 1, 1);
		rom[19] = iInstr(OPC_ADDIU, 0, 15, 2);
		rom[20] = iInstr(OPC_ADDIU, 0, 0, 77);
		rom[21] = rInstr(0, 6, 16, FN_ADDU);
		rom[22] = iInstr(OPC_BEQ, 0, 0, 1);
		rom[23] = rInstr(16, 0, 17, FN_OR);
		rom[24] = rInstr(17, 13, 18, FN_ADDU);
		rom[25] = iInstr(OPC_BEQ, 0, 0, -1);
	endtask

	assign instSramRdata = rom[romIndex(instSramAddr)];

	// Data RAM with a one-cycle read.
	always @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 64; i++) begin
				ram[i] <= {16'hDA7A, 16'(i)};
			end
		end else if (dataSramEn) begin
			if (dataSramWen == 4'hF) begin
				ram[dataSramAddr[7:2]] <= dataSramWdata;
			end
			dataSramRdata <= ram[dataSramAddr[7:2]];
		end
	end

	initial begin
		int cycles;
		int drain;
		cycles = 0;
		drain = 0;
		rst_i <= 1'b1;
		loadProgram();
		repeat (16) @(posedge clk);
		rst_i <= 1'b0;
		// Keep going a few cycles past the loop so its checks complete.
		while (myCpuTop_inst.traceCheck_inst.failCount == 0 && cycles < TIMEOUT_CYCLES
				&& drain < 4) begin
			@(negedge clk);
			cycles++;
			if (drain != 0 || debugWbPc == LOOP_PC) begin
				drain++;
			end
		end
		if (myCpuTop_inst.traceCheck_inst.failCount != 0) begin
			$display("Simulation FAILED");
			$fatal(1, "The retirement trace did not match the ISA model.");
		end else if (drain < 4) begin
			$display("Simulation FAILED");
			$fatal(1, "Timeout: the program never reached its final loop.");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/cpuTrace_checker.sv */
`default_nettype none

module cpuTrace_checker #(
	parameter cpuPkg::word_t RESET_PC = 32'hBFC00000
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic instSramEn_i,
	input wire cpuPkg::word_t instSramAddr_i,
	input wire cpuPkg::word_t instSramRdata_i,
	input wire logic dataSramEn_i,
	input wire logic [3:0] dataSramWen_i,
	input wire cpuPkg::word_t dataSramAddr_i,
	input wire cpuPkg::word_t dataSramWdata_i,
	input wire cpuPkg::word_t debugWbPc_i,
	input wire logic [3:0] debugWbRfWen_i,
	input wire cpuPkg::regAddr_t debugWbRfWnum_i,
	input wire cpuPkg::word_t debugWbRfWdata_i
);
	import cpuPkg::*;

	int failCount = 0;
	word_t fetched [0:63];
	word_t shadowRegs [0:31];
	word_t shadowMem [0:63];
	word_t expPc;
	word_t expNpc;
	word_t instr;
	word_t rsVal;
	word_t rtVal;
	word_t imm;
	word_t memAddr;
	word_t branchTarget;
	word_t expData;
	regAddr_t expNum;
	logic retire;
	logic expWe;
	logic isStore;
	logic isLoad;
	logic taken;

	function automatic logic [5:0] wordIndex(word_t addr);
		return addr[7:2];
	endfunction

	// The ROM is fixed, so every fetch seen on the bus is remembered by address.
	always_ff @(posedge clk) begin
		if (instSramEn_i) begin
			fetched[wordIndex(instSramAddr_i - RESET_PC)] <= instSramRdata_i;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ISA model of the instruction now retiring.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		retire = !rst_i && (debugWbPc_i != '0);
		instr = fetched[wordIndex(debugWbPc_i - RESET_PC)];
		rsVal = shadowRegs[instr[25:21]];
		rtVal = shadowRegs[instr[20:16]];
		imm = {{16{instr[15]}}, instr[15:0]};
		memAddr = rsVal + imm;
		branchTarget = debugWbPc_i + 32'd4 + {imm[29:0], 2'b00};
		expWe = 1'b0;
		expNum = instr[20:16];
		expData = '0;
		isStore = 1'b0;
		isLoad = 1'b0;
		taken = 1'b0;
		case (instr[31:26])
			OPC_SPECIAL: begin
				expWe = 1'b1;
				expNum = instr[15:11];
				case (instr[5:0])
					FN_ADDU: expData = rsVal + rtVal;
					FN_SUBU: expData = rsVal - rtVal;
					FN_AND: expData = rsVal & rtVal;
					FN_OR: expData = rsVal | rtVal;
					FN_SLT: expData = {31'b0, $signed(rsVal) < $signed(rtVal)};
					default: expWe = 1'b0;
				endcase
			end
			OPC_ADDIU: begin
				expWe = 1'b1;
				expData = rsVal + imm;
			end
			OPC_LW: begin
				expWe = 1'b1;
				isLoad = 1'b1;
				expData = shadowMem[wordIndex(memAddr)];
			end
			OPC_SW: isStore = 1'b1;
			OPC_BEQ: taken = (rsVal == rtVal);
			default: expWe = 1'b0;
		endcase
		// $0 is hardwired.
		if (expNum == '0) begin
			expWe = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			expPc <= RESET_PC;
			expNpc <= RESET_PC + 32'd4;
			for (int i = 0; i < 32; i++) begin
				shadowRegs[i] <= '0;
			end
		end else if (retire) begin
			expPc <= expNpc;
			expNpc <= taken ? branchTarget : expNpc + 32'd4;
			if (expWe) begin
				shadowRegs[expNum] <= expData;
			end
			if (isStore) begin
				shadowMem[wordIndex(memAddr)] <= rtVal;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Trace assertions.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	resetQuiet: assert property (@(posedge clk)
		rst_i |=> (debugWbRfWen_i == 4'h0) && (dataSramWen_i == 4'h0) && !dataSramEn_i)
	else begin
		failCount++;
		$error("FAIL resetQuiet: expected wen 0/0 en 0, actual %h/%h en %b",
			$sampled(debugWbRfWen_i), $sampled(dataSramWen_i), $sampled(dataSramEn_i));
	end

	fetchQuiet: assert property (@(posedge clk) rst_i |-> !instSramEn_i)
	else begin
		failCount++;
		$error("FAIL fetchQuiet: expected instruction enable 0, actual %b",
			$sampled(instSramEn_i));
	end

	bubbleQuiet: assert property (@(posedge clk)
		(!rst_i && !retire) |-> (debugWbRfWen_i == 4'h0))
	else begin
		failCount++;
		$error("FAIL bubbleQuiet: expected wen 0, actual %h", $sampled(debugWbRfWen_i));
	end

	firstFetch: assert property (@(posedge clk) $fell(rst_i) |-> (instSramAddr_i == RESET_PC))
	else begin
		failCount++;
		$error("FAIL firstFetch: expected %h, actual %h", RESET_PC, $sampled(instSramAddr_i));
	end

	retirePc: assert property (@(posedge clk) retire |-> (debugWbPc_i == expPc))
	else begin
		failCount++;
		$error("FAIL retirePc: expected %h, actual %h", $sampled(expPc), $sampled(debugWbPc_i));
	end

	wbEnable: assert property (@(posedge clk) retire |-> (debugWbRfWen_i == {4{expWe}}))
	else begin
		failCount++;
		$error("FAIL wbEnable at pc %h: expected %h, actual %h", $sampled(debugWbPc_i),
			{4{$sampled(expWe)}}, $sampled(debugWbRfWen_i));
	end

	wbValue: assert property (@(posedge clk)
		(retire && expWe) |-> (debugWbRfWnum_i == expNum) && (debugWbRfWdata_i == expData))
	else begin
		failCount++;
		$error("FAIL wbValue at pc %h: expected r%0d=%h, actual r%0d=%h",
			$sampled(debugWbPc_i), $sampled(expNum), $sampled(expData),
			$sampled(debugWbRfWnum_i), $sampled(debugWbRfWdata_i));
	end

	// Only a load or a store drives the data port, during its MEM cycle.
	memStrobes: assert property (@(posedge clk)
		!rst_i |-> ($past(dataSramEn_i) == (retire && (isStore || isLoad)))
			&& ($past(dataSramWen_i) == {4{retire && isStore}}))
	else begin
		failCount++;
		$error("FAIL memStrobes at pc %h: expected en %b store %b, actual en %b wen %h",
			$sampled(debugWbPc_i), $sampled(retire && (isStore || isLoad)),
			$sampled(retire && isStore), $past(dataSramEn_i), $past(dataSramWen_i));
	end

	// A store is in MEM exactly one cycle before it retires.
	storePort: assert property (@(posedge clk)
		(retire && isStore) |-> ($past(dataSramWen_i) == 4'hF)
			&& ($past(dataSramAddr_i) == memAddr) && ($past(dataSramWdata_i) == rtVal))
	else begin
		failCount++;
		$error("FAIL storePort at pc %h: expected %h<=%h, actual %h<=%h (wen %h)",
			$sampled(debugWbPc_i), $sampled(memAddr), $sampled(rtVal),
			$past(dataSramAddr_i), $past(dataSramWdata_i), $past(dataSramWen_i));
	end

endmodule

`default_nettype wire

/* hdl/myCpuTop.sv */
`default_nettype none

module myCpuTop #(
	parameter cpuPkg::word_t RESET_PC = 32'hBFC00000
) (
	input wire logic clk,
	input wire logic rst_i,
	output logic instSramEn_o,
	output cpuPkg::word_t instSramAddr_o,
	input wire cpuPkg::word_t instSramRdata_i,
	output logic dataSramEn_o,
	output logic [3:0] dataSramWen_o,
	output cpuPkg::word_t dataSramAddr_o,
	output cpuPkg::word_t dataSramWdata_o,
	input wire cpuPkg::word_t dataSramRdata_i,
	output cpuPkg::word_t debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output cpuPkg::regAddr_t debugWbRfWnum_o,
	output cpuPkg::word_t debugWbRfWdata_o
);
	import cpuPkg::*;

	word_t pcF;
	word_t ifIdInstr;
	word_t ifIdPc;
	word_t branchTarget;
	word_t wbResult;
	logic stall;
	logic branchTaken;
	logic usesRtD;
	logic isBranchD;
	logic fwdBranchA;
	logic fwdBranchB;
	regAddr_t rsD;
	regAddr_t rtD;
	fwdSel_t fwdA;
	fwdSel_t fwdB;
	idExReg_t idExD;
	idExReg_t idExQ;
	exMemReg_t exMemD;
	exMemReg_t exMemQ;
	memWbReg_t memWbQ;

	fetchStage #(.RESET_PC(RESET_PC)) fetchStage_inst (
		.clk            (clk),
		.rst_i          (rst_i),
		.stall_i        (stall),
		.branchTaken_i  (branchTaken),
		.branchTarget_i (branchTarget),
		.pc_o           (pcF)
	);

	decodeStage decodeStage_inst (
		.clk            (clk),
		.rst_i          (rst_i),
		.instr_i        (ifIdInstr),
		.pc_i           (ifIdPc),
		.wbWe_i         (memWbQ.regWrite),
		.wbAddr_i       (memWbQ.writeReg),
		.wbData_i       (wbResult),
		.exMemAluOut_i  (exMemQ.aluOut),
		.fwdBranchA_i   (fwdBranchA),
		.fwdBranchB_i   (fwdBranchB),
		.idEx_o         (idExD),
		.rs_o           (rsD),
		.rt_o           (rtD),
		.usesRt_o       (usesRtD),
		.isBranch_o     (isBranchD),
		.branchTaken_o  (branchTaken),
		.branchTarget_o (branchTarget)
	);

	executeStage executeStage_inst (
		.idEx_i      (idExQ),
		.fwdA_i      (fwdA),
		.fwdB_i      (fwdB),
		.memAluOut_i (exMemQ.aluOut),
		.wbResult_i  (wbResult),
		.exMem_o     (exMemD)
	);

	hazardUnit hazardUnit_inst (
		.rsD_i        (rsD),
		.rtD_i        (rtD),
		.usesRtD_i    (usesRtD),
		.isBranchD_i  (isBranchD),
		.idEx_i       (idExQ),
		.exMem_i      (exMemQ),
		.memWb_i      (memWbQ),
		.stall_o      (stall),
		.fwdA_o       (fwdA),
		.fwdB_o       (fwdB),
		.fwdBranchA_o (fwdBranchA),
		.fwdBranchB_o (fwdBranchB)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline registers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ifIdInstr <= '0;
			ifIdPc <= '0;
		end else if (!stall) begin
			ifIdInstr <= instSramRdata_i;
			ifIdPc <= pcF;
		end
	end

	// A stall sends a bubble into EX.
	always_ff @(posedge clk) begin
		if (rst_i || stall) begin
			idExQ <= '0;
		end else begin
			idExQ <= idExD;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			exMemQ <= '0;
			memWbQ <= '0;
		end else begin
			exMemQ <= exMemD;
			memWbQ <= '{regWrite: exMemQ.regWrite, memRead: exMemQ.memRead,
				aluOut: exMemQ.aluOut, writeReg: exMemQ.writeReg, pc: exMemQ.pc};
		end
	end

	// Load data arrives one cycle after the address, when the load is in WB.
	assign wbResult = memWbQ.memRead ? dataSramRdata_i : memWbQ.aluOut;

	assign instSramEn_o = !rst_i;
	assign instSramAddr_o = pcF;
	assign dataSramEn_o = exMemQ.memRead || exMemQ.memWrite;
	assign dataSramWen_o = {4{exMemQ.memWrite}};
	assign dataSramAddr_o = exMemQ.aluOut;
	assign dataSramWdata_o = exMemQ.storeData;

	assign debugWbPc_o = memWbQ.pc;
	assign debugWbRfWen_o = {4{memWbQ.regWrite}};
	assign debugWbRfWnum_o = memWbQ.writeReg;
	assign debugWbRfWdata_o = wbResult;

endmodule

`default_nettype wire

/* hdl/hazardUnit.sv */
`default_nettype none

module hazardUnit (
	input wire cpuPkg::regAddr_t rsD_i,
	input wire cpuPkg::regAddr_t rtD_i,
	input wire logic usesRtD_i,
	input wire logic isBranchD_i,
	input wire cpuPkg::idExReg_t idEx_i,
	input wire cpuPkg::exMemReg_t exMem_i,
	input wire cpuPkg::memWbReg_t memWb_i,
	output logic stall_o,
	output cpuPkg::fwdSel_t fwdA_o,
	output cpuPkg::fwdSel_t fwdB_o,
	output logic fwdBranchA_o,
	output logic fwdBranchB_o
);
	import cpuPkg::*;

	regAddr_t destE;
	logic writesE;
	logic hitE;
	logic rsHitM;
	logic rtHitM;

	// Destination of the instruction now in EX.
	assign destE = idEx_i.ctrl.regDstRd ? idEx_i.rd : idEx_i.rt;
	assign writesE = idEx_i.ctrl.regWrite && (destE != '0);
	assign hitE = writesE && ((destE == rsD_i) || (usesRtD_i && destE == rtD_i));
	assign rsHitM = exMem_i.regWrite && (exMem_i.writeReg == rsD_i);
	assign rtHitM = exMem_i.regWrite && usesRtD_i && (exMem_i.writeReg == rtD_i);

	// Load-use, branch on an EX result, and branch on a load still in MEM.
	assign stall_o = (hitE && (idEx_i.ctrl.memRead || isBranchD_i))
		|| (isBranchD_i && exMem_i.memRead && (rsHitM || rtHitM));

	assign fwdBranchA_o = isBranchD_i && rsHitM && !exMem_i.memRead;
	assign fwdBranchB_o = isBranchD_i && rtHitM && !exMem_i.memRead;

	// Newer producer first.
	function automatic fwdSel_t pickFwd(regAddr_t src);
		if (exMem_i.regWrite && exMem_i.writeReg == src) begin
			return FWD_MEM;
		end
		if (memWb_i.regWrite && memWb_i.writeReg == src) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	always_comb begin
		fwdA_o = pickFwd(idEx_i.rs);
		fwdB_o = pickFwd(idEx_i.rt);
	end

endmodule

`default_nettype wire

/* hdl/executeStage.sv */
`default_nettype none

module executeStage (
	input wire cpuPkg::idExReg_t idEx_i,
	input wire cpuPkg::fwdSel_t fwdA_i,
	input wire cpuPkg::fwdSel_t fwdB_i,
	input wire cpuPkg::word_t memAluOut_i,
	input wire cpuPkg::word_t wbResult_i,
	output cpuPkg::exMemReg_t exMem_o
);
	import cpuPkg::*;

	word_t opA;
	word_t rtFwd;
	word_t opB;
	word_t aluOut;
	regAddr_t writeReg;

	function automatic word_t fwdMux(fwdSel_t sel, word_t regValue);
		case (sel)
			FWD_MEM: return memAluOut_i;
			FWD_WB: return wbResult_i;
			default: return regValue;
		endcase
	endfunction

	always_comb begin
		opA = fwdMux(fwdA_i, idEx_i.rsValue);
		rtFwd = fwdMux(fwdB_i, idEx_i.rtValue);
	end

	assign opB = idEx_i.ctrl.aluSrcImm ? idEx_i.imm : rtFwd;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ALU.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (idEx_i.ctrl.aluOp)
			ALU_ADD: aluOut = opA + opB;
			ALU_SUB: aluOut = opA - opB;
			ALU_AND: aluOut = opA & opB;
			ALU_OR: aluOut = opA | opB;
			ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
			default: aluOut = '0;
		endcase
	end

	assign writeReg = idEx_i.ctrl.regDstRd ? idEx_i.rd : idEx_i.rt;

	// Writes to $0 are dropped here so later stages never match on it.
	assign exMem_o = '{regWrite: idEx_i.ctrl.regWrite && (writeReg != '0),
		memRead: idEx_i.ctrl.memRead, memWrite: idEx_i.ctrl.memWrite,
		aluOut: aluOut, storeData: rtFwd, writeReg: writeReg, pc: idEx_i.pc};

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`default_nettype none

module decodeStage (
	input wire logic clk,
	input wire logic rst_i,
	input wire cpuPkg::word_t instr_i,
	input wire cpuPkg::word_t pc_i,
	input wire logic wbWe_i,
	input wire cpuPkg::regAddr_t wbAddr_i,
	input wire cpuPkg::word_t wbData_i,
	input wire cpuPkg::word_t exMemAluOut_i,
	input wire logic fwdBranchA_i,
	input wire logic fwdBranchB_i,
	output cpuPkg::idExReg_t idEx_o,
	output cpuPkg::regAddr_t rs_o,
	output cpuPkg::regAddr_t rt_o,
	output logic usesRt_o,
	output logic isBranch_o,
	output logic branchTaken_o,
	output cpuPkg::word_t branchTarget_o
);
	import cpuPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rd;
	word_t immExt;
	word_t rsRead;
	word_t rtRead;
	word_t rsCmp;
	word_t rtCmp;
	ctrl_t ctrl;

	assign opcode = instr_i[31:26];
	assign funct = instr_i[5:0];
	assign rs_o = instr_i[25:21];
	assign rt_o = instr_i[20:16];
	assign rd = instr_i[15:11];
	assign immExt = {{16{instr_i[15]}}, instr_i[15:0]};

	regFile regFile_inst (
		.clk      (clk),
		.rst_i    (rst_i),
		.raddrA_i (rs_o),
		.raddrB_i (rt_o),
		.rdataA_o (rsRead),
		.rdataB_o (rtRead),
		.we_i     (wbWe_i),
		.waddr_i  (wbAddr_i),
		.wdata_i  (wbData_i)
	);

	always_comb begin
		ctrl = '0;
		usesRt_o = 1'b0;
		isBranch_o = 1'b0;
		case (opcode)
			OPC_SPECIAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				usesRt_o = 1'b1;
				case (funct)
					FN_ADDU: ctrl.aluOp = ALU_ADD;
					FN_SUBU: ctrl.aluOp = ALU_SUB;
					FN_AND: ctrl.aluOp = ALU_AND;
					FN_OR: ctrl.aluOp = ALU_OR;
					FN_SLT: ctrl.aluOp = ALU_SLT;
					default: begin
						ctrl = '0;
						usesRt_o = 1'b0;
					end
				endcase
			end
			OPC_ADDIU: ctrl = '{regWrite: 1'b1, aluSrcImm: 1'b1, aluOp: ALU_ADD, default: '0};
			OPC_LW: ctrl = '{regWrite: 1'b1, memRead: 1'b1, aluSrcImm: 1'b1, aluOp: ALU_ADD,
				default: '0};
			OPC_SW: begin
				ctrl = '{memWrite: 1'b1, aluSrcImm: 1'b1, aluOp: ALU_ADD, default: '0};
				usesRt_o = 1'b1;
			end
			OPC_BEQ: begin
				isBranch_o = 1'b1;
				usesRt_o = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	// Branch compare in decode. Only the EX/MEM result can be forwarded here.
	assign rsCmp = fwdBranchA_i ? exMemAluOut_i : rsRead;
	assign rtCmp = fwdBranchB_i ? exMemAluOut_i : rtRead;
	assign branchTaken_o = isBranch_o && (rsCmp == rtCmp);
	assign branchTarget_o = pc_i + 32'd4 + {immExt[29:0], 2'b00};

	assign idEx_o = '{ctrl: ctrl, rsValue: rsRead, rtValue: rtRead, imm: immExt,
		rs: rs_o, rt: rt_o, rd: rd, pc: pc_i};

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic rst_i,
	input wire cpuPkg::regAddr_t raddrA_i,
	input wire cpuPkg::regAddr_t raddrB_i,
	output cpuPkg::word_t rdataA_o,
	output cpuPkg::word_t rdataB_o,
	input wire logic we_i,
	input wire cpuPkg::regAddr_t waddr_i,
	input wire cpuPkg::word_t wdata_i
);
	import cpuPkg::*;

	word_t regs [1:31];

	// Write-through, so a reader in the write cycle sees the new value.
	function automatic word_t readPort(regAddr_t addr);
		if (addr == '0) begin
			return '0;
		end
		if (we_i && addr == waddr_i) begin
			return wdata_i;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdataA_o = readPort(raddrA_i);
		rdataB_o = readPort(raddrB_i);
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

endmodule

`default_nettype wire

/* hdl/fetchStage.sv */
`default_nettype none

module fetchStage #(
	parameter cpuPkg::word_t RESET_PC = 32'hBFC00000
) (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic stall_i,
	input wire logic branchTaken_i,
	input wire cpuPkg::word_t branchTarget_i,
	output cpuPkg::word_t pc_o
);
	import cpuPkg::*;

	word_t pcNext;

	// A stall wins over a branch, since the branch operands are not ready yet.
	always_comb begin
		if (stall_i) begin
			pcNext = pc_o;
		end else if (branchTaken_i) begin
			pcNext = branchTarget_i;
		end else begin
			pcNext = pc_o + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_o <= RESET_PC;
		end else begin
			pc_o <= pcNext;
		end
	end

endmodule

`default_nettype wire

/* hdl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [1:0] fwdSel_t;

	localparam aluOp_t ALU_ADD = 3'd0;
	localparam aluOp_t ALU_SUB = 3'd1;
	localparam aluOp_t ALU_AND = 3'd2;
	localparam aluOp_t ALU_OR = 3'd3;
	localparam aluOp_t ALU_SLT = 3'd4;

	// Primary opcodes and SPECIAL function codes.
	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_LW = 6'h23;
	localparam logic [5:0] OPC_SW = 6'h2b;
	localparam logic [5:0] OPC_BEQ = 6'h04;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	localparam fwdSel_t FWD_NONE = 2'd0;
	localparam fwdSel_t FWD_MEM = 2'd1;
	localparam fwdSel_t FWD_WB = 2'd2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline register contents.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic aluSrcImm;
		logic regDstRd;
		aluOp_t aluOp;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t rsValue;
		word_t rtValue;
		word_t imm;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		word_t pc;
	} idExReg_t;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		word_t aluOut;
		word_t storeData;
		regAddr_t writeReg;
		word_t pc;
	} exMemReg_t;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		word_t aluOut;
		regAddr_t writeReg;
		word_t pc;
	} memWbReg_t;

endpackage

`default_nettype wire
